// File: rtl/gshare_pkg.sv
package gshare_pkg;

    // table geometry
    localparam int INDEX_W  = 10;            // index bits, also the history length
    localparam int NUM_SETS = 2 ** INDEX_W;  // one counter per index

    // branch address
    localparam int PC_W   = 32;
    localparam int PC_LSB = 2;               // first address bit in the hash, skips byte offset

    typedef logic [PC_W-1:0]    pc_t;
    typedef logic [INDEX_W-1:0] pht_index_t;
    typedef logic [INDEX_W-1:0] ghr_t;       // newest outcome sits in bit 0
    typedef logic [1:0]         counter_t;   // two-bit saturating counter

    // counter encoding: 0 strongly not taken .. 3 strongly taken
    localparam counter_t CTR_RESET = 2'd0;   // strongly not taken
    localparam counter_t CTR_MAX   = 2'd3;   // saturation ceiling

    // gshare hash, used on both the lookup and the resolve side
    function automatic pht_index_t pht_hash(
        input pc_t  pc,
        input ghr_t ghr
    );
        pht_index_t pc_bits;
        pc_bits = pc[PC_LSB +: INDEX_W];
        return pc_bits ^ ghr;
    endfunction

    // history update: oldest bit drops out, outcome enters at bit 0
    function automatic ghr_t ghr_shift(
        input ghr_t ghr,
        input logic taken
    );
        return {ghr[INDEX_W-2:0], taken};
    endfunction

endpackage

// File: rtl/gshare_lookup.sv
`timescale 1ns/1ps

module gshare_lookup (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   lookup,         // decode asks for a prediction
    input  gshare_pkg::pc_t        lookup_pc,
    input  logic                   prediction,     // direction from the counter table
    input  logic                   repair,         // history repair after a mispredict
    input  gshare_pkg::ghr_t       repair_ghr,
    output logic                   read,
    output gshare_pkg::pht_index_t rindex,
    output logic                   predict_taken,
    output gshare_pkg::ghr_t       predict_ghr     // snapshot carried down the pipe
);
    import gshare_pkg::*;

    ghr_t ghr_q;   // global history, speculative
    ghr_t ghr_d;

    // table read port
    assign read   = lookup;
    assign rindex = pht_hash(lookup_pc, ghr_q);

    // the table already returns 0 when read is low
    assign predict_taken = prediction;
    assign predict_ghr   = ghr_q;                  // history used for this lookup

    // next history
    // a repair restores the history from the resolved branch and drops
    // whatever the lookup in the same cycle would have shifted in
    always_comb begin
        ghr_d = ghr_q;
        if (repair) begin
            ghr_d = repair_ghr;                    // already shifted by the resolve side
        end else if (lookup) begin
            ghr_d = ghr_shift(ghr_q, prediction);  // speculative shift
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ghr_q <= '0;
        end else begin
            ghr_q <= ghr_d;
        end
    end

    // whole read path stays quiet without a lookup
    a_idle_not_taken: assert property (
        @(posedge clk) disable iff (!rst_n)
        !lookup |-> !predict_taken
    ) else $error("predict_taken high without lookup");

endmodule

// File: rtl/gshare_pht.sv
`timescale 1ns/1ps

module gshare_pht (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   read,
    input  gshare_pkg::pht_index_t rindex,    // decode side index
    input  logic                   load,
    input  gshare_pkg::pht_index_t windex,    // execute side index
    input  logic                   wtaken,    // resolved outcome
    output logic                   prediction
);
    import gshare_pkg::*;

    counter_t ctr_q [NUM_SETS];   // pattern history table
    counter_t rd_ctr;
    counter_t wr_ctr;
    counter_t upd_ctr;
    logic     fwd;

    assign rd_ctr = ctr_q[rindex];
    assign wr_ctr = ctr_q[windex];

    // read and write to the same entry in one cycle
    assign fwd = load && (rindex == windex);

    // read side
    always_comb begin
        if (!read) begin
            prediction = 1'b0;
        end else if (fwd) begin
            prediction = wtaken;          // resolved outcome wins over the stale counter
        end else begin
            prediction = rd_ctr[1];       // upper bit set means taken
        end
    end

    // saturating update of the written entry
    always_comb begin
        upd_ctr = wr_ctr;
        if (wtaken) begin
            if (wr_ctr != CTR_MAX) begin
                upd_ctr = wr_ctr + 2'd1;  // count toward strongly taken
            end
        end else begin
            if (wr_ctr != '0) begin
                upd_ctr = wr_ctr - 2'd1;  // count toward strongly not taken
            end
        end
    end

    // write lands at the edge so a lookup one cycle later sees it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                ctr_q[i] <= CTR_RESET;
            end
        end else if (load) begin
            ctr_q[windex] <= upd_ctr;
        end
    end

    // written entry stays inside the counter range
    a_ctr_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        load |=> ctr_q[$past(windex)] <= CTR_MAX
    ) else $error("counter above ceiling");

endmodule

// File: rtl/gshare_resolve.sv
`timescale 1ns/1ps

module gshare_resolve (
    input  logic                   clk,                // assertion sampling only
    input  logic                   resolve,            // execute resolves a branch
    input  gshare_pkg::pc_t        resolve_pc,
    input  gshare_pkg::ghr_t       resolve_ghr,        // snapshot taken at lookup
    input  logic                   resolve_taken,      // real outcome
    input  logic                   resolve_predicted,  // direction given at lookup
    output logic                   load,
    output gshare_pkg::pht_index_t windex,
    output logic                   wtaken,
    output logic                   repair,
    output gshare_pkg::ghr_t       repair_ghr,
    output logic                   mispredict
);
    import gshare_pkg::*;

    logic wrong;   // outcome differs from what decode was told

    assign wrong = resolve_taken != resolve_predicted;

    // training write uses the lookup hash so it hits the same entry
    assign load   = resolve;
    assign windex = pht_hash(resolve_pc, resolve_ghr);
    assign wtaken = resolve_taken;

    assign mispredict = resolve && wrong;

    // history repair
    // the snapshot is the history before this branch, so the correct
    // history is the snapshot with the real outcome shifted in
    assign repair     = mispredict;
    assign repair_ghr = ghr_shift(resolve_ghr, resolve_taken);

    a_repair_load: assert property (
        @(posedge clk) repair |-> load
    ) else $error("history repair without table write");

endmodule

// File: rtl/gshare_predictor.sv
`timescale 1ns/1ps

module gshare_predictor (
    input  logic                   clk,
    input  logic                   rst_n,
    // decode side
    input  logic                   lookup,
    input  gshare_pkg::pc_t        lookup_pc,
    output logic                   predict_taken,
    output gshare_pkg::ghr_t       predict_ghr,
    // execute side
    input  logic                   resolve,
    input  gshare_pkg::pc_t        resolve_pc,
    input  gshare_pkg::ghr_t       resolve_ghr,
    input  logic                   resolve_taken,
    input  logic                   resolve_predicted,
    output logic                   mispredict
);
    import gshare_pkg::*;

    // lookup <-> table
    logic       read;
    pht_index_t rindex;
    logic       prediction;

    // resolve -> table
    logic       load;
    pht_index_t windex;
    logic       wtaken;

    // resolve -> lookup
    logic       repair;
    ghr_t       repair_ghr;

    gshare_lookup i_lookup (
        .clk           (clk),
        .rst_n         (rst_n),
        .lookup        (lookup),
        .lookup_pc     (lookup_pc),
        .prediction    (prediction),
        .repair        (repair),
        .repair_ghr    (repair_ghr),
        .read          (read),
        .rindex        (rindex),
        .predict_taken (predict_taken),
        .predict_ghr   (predict_ghr)
    );

    gshare_pht i_pht (
        .clk        (clk),
        .rst_n      (rst_n),
        .read       (read),
        .rindex     (rindex),
        .load       (load),
        .windex     (windex),
        .wtaken     (wtaken),
        .prediction (prediction)
    );

    gshare_resolve i_resolve (
        .clk               (clk),
        .resolve           (resolve),
        .resolve_pc        (resolve_pc),
        .resolve_ghr       (resolve_ghr),
        .resolve_taken     (resolve_taken),
        .resolve_predicted (resolve_predicted),
        .load              (load),
        .windex            (windex),
        .wtaken            (wtaken),
        .repair            (repair),
        .repair_ghr        (repair_ghr),
        .mispredict        (mispredict)
    );

endmodule

// File: sim/tb_gshare_model.svh
`ifndef TB_GSHARE_MODEL_SVH
`define TB_GSHARE_MODEL_SVH

// reference copy of the counter table and the history
counter_t ref_ctr [NUM_SETS];
ghr_t     ref_ghr;
int       check_count = 0;
int       error_count = 0;

// address bits above the byte offset, xor the history
function automatic pht_index_t index_of(input pc_t pc, input ghr_t ghr);
    return pht_index_t'(pc >> PC_LSB) ^ ghr;
endfunction

// expected direction for the current cycle
function automatic logic model_predict(
    input logic lk,
    input pc_t  lpc,
    input logic rs,
    input pc_t  rpc,
    input ghr_t rghr,
    input logic rt
);
    if (!lk) begin
        return 1'b0;
    end
    if (rs && index_of(lpc, ref_ghr) == index_of(rpc, rghr)) begin
        return rt;                                     // resolved outcome forwarded
    end
    return ref_ctr[index_of(lpc, ref_ghr)] >= 2'd2;   // weakly taken or above
endfunction

task automatic reset_reference();
    for (int i = 0; i < NUM_SETS; i++) begin
        ref_ctr[i] = CTR_RESET;
    end
    ref_ghr = '0;
endtask

// state after the coming clock edge
task automatic step_reference(
    input logic lk,
    input logic rs,
    input logic rt,
    input logic rp,
    input pc_t  rpc,
    input ghr_t rghr,
    input logic predicted
);
    pht_index_t w;
    w = index_of(rpc, rghr);
    if (rs && rt && ref_ctr[w] != CTR_MAX) begin
        ref_ctr[w] = ref_ctr[w] + 2'd1;
    end else if (rs && !rt && ref_ctr[w] != 2'd0) begin
        ref_ctr[w] = ref_ctr[w] - 2'd1;
    end
    if (rs && rt != rp) begin
        ref_ghr = {rghr[INDEX_W-2:0], rt};            // repair wins
    end else if (lk) begin
        ref_ghr = {ref_ghr[INDEX_W-2:0], predicted};
    end
endtask

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
endtask

`endif

// File: sim/tb_gshare_predictor.sv
`timescale 1ns/1ps

module tb_gshare_predictor;
    import gshare_pkg::*;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 4;
    // cycle budget of each test, the watchdog is sized from their sum
    localparam int RESET_TEST    = 12;
    localparam int TRAIN_TEST    = 20;
    localparam int HISTORY_TEST  = 18;
    localparam int REPAIR_TEST   = 10;
    localparam int FORWARD_TEST  = 8;
    localparam int RANDOM_CYCLES = 500;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + RESET_TEST + TRAIN_TEST + HISTORY_TEST
                                 + REPAIR_TEST + FORWARD_TEST + RANDOM_CYCLES + 6;
    localparam int TIMEOUT_NS    = (TOTAL_CYCLES + 100) * CLK_PERIOD;

    // table entries used by the directed tests
    localparam pht_index_t IDX_A = 10'h155;
    localparam pht_index_t IDX_B = 10'h2c9;
    localparam pht_index_t IDX_C = 10'h0e3;
    localparam pht_index_t IDX_D = 10'h3a5;

    logic clk = 1'b0;
    logic rst_n;
    logic lookup;
    pc_t  lookup_pc;
    logic predict_taken;
    ghr_t predict_ghr;
    logic resolve;
    pc_t  resolve_pc;
    ghr_t resolve_ghr;
    logic resolve_taken;
    logic resolve_predicted;
    logic mispredict;

    // directed expectations, applied with the inputs of the same cycle
    logic dir_taken_en;
    logic dir_taken;
    logic dir_ghr_en;
    ghr_t dir_ghr;
    logic dir_mis_en;
    logic dir_mis;
    logic pend_taken_en;
    logic pend_taken;
    logic pend_ghr_en;
    ghr_t pend_ghr;
    logic pend_mis_en;
    logic pend_mis;

    logic [31:0] lfsr_state = 32'hd6c3_5b33;
    pc_t         snap_pc_q[$];    // lookups waiting to be resolved
    ghr_t        snap_ghr_q[$];
    string       test_name;
    int          errors_at_start;
    int          test_count = 0;
    int          failed_tests = 0;

    `include "tb_gshare_model.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    gshare_predictor i_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .lookup            (lookup),
        .lookup_pc         (lookup_pc),
        .predict_taken     (predict_taken),
        .predict_ghr       (predict_ghr),
        .resolve           (resolve),
        .resolve_pc        (resolve_pc),
        .resolve_ghr       (resolve_ghr),
        .resolve_taken     (resolve_taken),
        .resolve_predicted (resolve_predicted),
        .mispredict        (mispredict)
    );

    // outputs are settled half a cycle after the inputs change
    always @(negedge clk) begin : compare_outputs
        logic exp_taken;
        logic exp_mis;
        if (!rst_n) begin
            reset_reference();
        end else begin
            exp_taken = model_predict(lookup, lookup_pc, resolve, resolve_pc,
                                      resolve_ghr, resolve_taken);
            exp_mis   = resolve && (resolve_taken != resolve_predicted);
            check_value("predict_taken", 32'(predict_taken), 32'(exp_taken));
            check_value("predict_ghr", 32'(predict_ghr), 32'(ref_ghr));
            check_value("mispredict", 32'(mispredict), 32'(exp_mis));
            if (dir_taken_en) begin
                check_value("directed predict_taken", 32'(predict_taken), 32'(dir_taken));
            end
            if (dir_ghr_en) begin
                check_value("directed predict_ghr", 32'(predict_ghr), 32'(dir_ghr));
            end
            if (dir_mis_en) begin
                check_value("directed mispredict", 32'(mispredict), 32'(dir_mis));
            end
            step_reference(lookup, resolve, resolve_taken, resolve_predicted,
                           resolve_pc, resolve_ghr, exp_taken);
        end
    end

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    // an address that lands on idx under history ghr
    function automatic pc_t pc_for_index(input pht_index_t idx, input ghr_t ghr);
        return pc_t'(idx ^ ghr) << PC_LSB;
    endfunction

    task automatic taken_due(input logic v);
        pend_taken_en = 1'b1;
        pend_taken    = v;
    endtask

    task automatic ghr_due(input ghr_t v);
        pend_ghr_en = 1'b1;
        pend_ghr    = v;
    endtask

    task automatic mispredict_due(input logic v);
        pend_mis_en = 1'b1;
        pend_mis    = v;
    endtask

    // called at a rising edge, returns at the next one
    task automatic drive(
        input logic lk,
        input pc_t  lpc,
        input logic rs,
        input pc_t  rpc,
        input ghr_t rghr,
        input logic rt,
        input logic rp
    );
        lookup            <= lk;
        lookup_pc         <= lpc;
        resolve           <= rs;
        resolve_pc        <= rpc;
        resolve_ghr       <= rghr;
        resolve_taken     <= rt;
        resolve_predicted <= rp;
        dir_taken_en      <= pend_taken_en;
        dir_taken         <= pend_taken;
        dir_ghr_en        <= pend_ghr_en;
        dir_ghr           <= pend_ghr;
        dir_mis_en        <= pend_mis_en;
        dir_mis           <= pend_mis;
        pend_taken_en = 1'b0;
        pend_ghr_en   = 1'b0;
        pend_mis_en   = 1'b0;
        @(posedge clk);
    endtask

    task automatic do_lookup(input pc_t pc);
        drive(1'b1, pc, 1'b0, '0, '0, 1'b0, 1'b0);
    endtask

    task automatic do_resolve(input pc_t pc, input ghr_t ghr, input logic t, input logic p);
        drive(1'b0, '0, 1'b1, pc, ghr, t, p);
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        int errs;
        drive(1'b0, '0, 1'b0, '0, '0, 1'b0, 1'b0);
        errs = error_count - errors_at_start;
        test_count++;
        if (errs == 0) begin
            $display("test %0d %s: ok", test_count, test_name);
        end else begin
            failed_tests++;
            $display("test %0d %s: FAILED with %0d errors", test_count, test_name, errs);
        end
    endtask

    task automatic after_reset();
        logic [31:0] r;
        start_test("after reset");
        for (int i = 0; i < 8; i++) begin
            rand_bits(30, r);
            taken_due(1'b0);
            ghr_due('0);
            do_lookup(pc_t'(r[29:0]) << PC_LSB);
        end
        end_test();
    endtask

    task automatic counter_training();
        start_test("counter training");
        repeat (2) do_resolve(pc_for_index(IDX_A, '0), '0, 1'b1, 1'b1);
        taken_due(1'b1);                       // weakly taken
        do_lookup(pc_for_index(IDX_A, ref_ghr));
        repeat (3) do_resolve(pc_for_index(IDX_A, '0), '0, 1'b1, 1'b1);
        do_resolve(pc_for_index(IDX_A, '0), '0, 1'b0, 1'b0);
        taken_due(1'b1);                       // ceiling held, one step down still taken
        do_lookup(pc_for_index(IDX_A, ref_ghr));
        repeat (4) do_resolve(pc_for_index(IDX_A, '0), '0, 1'b0, 1'b0);
        do_resolve(pc_for_index(IDX_A, '0), '0, 1'b1, 1'b1);
        taken_due(1'b0);                       // floor held, one taken stays below
        do_lookup(pc_for_index(IDX_A, ref_ghr));
        end_test();
    endtask

    task automatic speculative_history();
        ghr_t hist;
        start_test("speculative history");
        repeat (3) do_resolve(pc_for_index(IDX_B, '0), '0, 1'b1, 1'b1);
        hist = ref_ghr;
        for (int i = 0; i < 6; i++) begin
            taken_due(1'b1);
            ghr_due(hist);
            do_lookup(pc_for_index(IDX_B, ref_ghr));
            hist = {hist[INDEX_W-2:0], 1'b1};
        end
        for (int i = 0; i < 4; i++) begin
            taken_due(1'b0);
            ghr_due(hist);
            do_lookup(pc_for_index(IDX_A, ref_ghr));
            hist = {hist[INDEX_W-2:0], 1'b0};
        end
        ghr_due(hist);                         // no lookup, history holds
        drive(1'b0, '0, 1'b0, '0, '0, 1'b0, 1'b0);
        end_test();
    endtask

    task automatic mispredict_repair();
        ghr_t snap;
        pc_t  pc;
        start_test("mispredict repair");
        snap = ref_ghr;
        pc   = pc_for_index(IDX_C, snap);
        taken_due(1'b0);
        do_lookup(pc);
        mispredict_due(1'b1);                  // predicted not taken, went taken
        do_resolve(pc, snap, 1'b1, 1'b0);
        ghr_due({snap[INDEX_W-2:0], 1'b1});
        do_lookup(pc_for_index(IDX_C, ref_ghr));
        // repair and lookup in one cycle
        snap = ref_ghr;
        pc   = pc_for_index(IDX_B, snap);
        taken_due(1'b1);
        do_lookup(pc);
        mispredict_due(1'b1);
        drive(1'b1, pc_for_index(IDX_C, ref_ghr), 1'b1, pc, snap, 1'b0, 1'b1);
        ghr_due({snap[INDEX_W-2:0], 1'b0});
        mispredict_due(1'b0);
        do_resolve(pc_for_index(IDX_C, '0), '0, 1'b0, 1'b0);
        end_test();
    endtask

    task automatic same_index_forward();
        ghr_t rg;
        start_test("same index forward");
        rg = 10'h2a7;
        taken_due(1'b1);                       // untrained entry
        drive(1'b1, pc_for_index(IDX_D, ref_ghr), 1'b1, pc_for_index(IDX_D, rg), rg,
              1'b1, 1'b1);
        taken_due(1'b0);                       // weakly taken entry
        drive(1'b1, pc_for_index(IDX_B, ref_ghr), 1'b1, pc_for_index(IDX_B, rg), rg,
              1'b0, 1'b0);
        taken_due(1'b0);                       // other index, stored counter decides
        drive(1'b1, pc_for_index(IDX_C, ref_ghr), 1'b1, pc_for_index(IDX_D, rg), rg,
              1'b1, 1'b1);
        end_test();
    endtask

    task automatic random_mix();
        logic [31:0] r;
        logic        lk;
        pc_t         lpc;
        logic        rs;
        pc_t         rpc;
        ghr_t        rghr;
        logic        rt;
        logic        rp;
        start_test("random mix");
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            rand_bits(1, r);
            lk = r[0];
            rand_bits(8, r);
            lpc  = pc_t'(r[7:0]) << PC_LSB;    // small pool so branches repeat
            rs   = 1'b0;
            rpc  = '0;
            rghr = '0;
            rt   = 1'b0;
            rp   = 1'b0;
            if (snap_pc_q.size() > 0) begin
                rand_bits(1, r);
                rs = r[0];
            end
            if (rs) begin
                rpc  = snap_pc_q.pop_front();
                rghr = snap_ghr_q.pop_front();
                rand_bits(2, r);
                rt = r[0];
                rp = r[1];
            end
            if (lk) begin
                snap_pc_q.push_back(lpc);
                snap_ghr_q.push_back(ref_ghr);
            end
            drive(lk, lpc, rs, rpc, rghr, rt, rp);
        end
        end_test();
    endtask

    initial begin
        rst_n             <= 1'b0;
        lookup            <= 1'b0;
        lookup_pc         <= '0;
        resolve           <= 1'b0;
        resolve_pc        <= '0;
        resolve_ghr       <= '0;
        resolve_taken     <= 1'b0;
        resolve_predicted <= 1'b0;
        dir_taken_en      <= 1'b0;
        dir_taken         <= 1'b0;
        dir_ghr_en        <= 1'b0;
        dir_ghr           <= '0;
        dir_mis_en        <= 1'b0;
        dir_mis           <= 1'b0;
        pend_taken_en = 1'b0;
        pend_taken    = 1'b0;
        pend_ghr_en   = 1'b0;
        pend_ghr      = '0;
        pend_mis_en   = 1'b0;
        pend_mis      = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        after_reset();
        counter_training();
        speculative_history();
        mispredict_repair();
        same_index_forward();
        random_mix();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0 && failed_tests == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: gshare_predictor.f
+incdir+sim
rtl/gshare_pkg.sv
rtl/gshare_lookup.sv
rtl/gshare_pht.sv
rtl/gshare_resolve.sv
rtl/gshare_predictor.sv
sim/tb_gshare_predictor.sv

// File: run_sim.sh
#!/bin/sh
# build and run the gshare predictor testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_gshare_predictor
LOG=sim.log

verilator --binary --timing --assert \
    --top-module "$TOP" \
    -f gshare_predictor.f \
    -o "V$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./obj_dir/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints its verdict into the log
if grep -q "Simulation failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi

echo "PASS"
exit 0
